// ==== Bender.yml ====
package:
  name: cpu_axi_subsys

sources:
  - files:
      - src/axi_bridge_pkg.sv
      - src/bridge_ctrl.sv
      - src/axi_read_path.sv
      - src/axi_write_path.sv
      - src/axi_sram_slave.sv
      - src/cpu_axi_subsys.sv
  - target: test
    files:
      - test/cpu_axi_subsys_tb.sv

// ==== cpu_axi_subsys.f ====
src/axi_bridge_pkg.sv
src/bridge_ctrl.sv
src/axi_read_path.sv
src/axi_write_path.sv
src/axi_sram_slave.sv
src/cpu_axi_subsys.sv
test/cpu_axi_subsys_tb.sv

// ==== src/axi_bridge_pkg.sv ====
package axi_bridge_pkg;

    // bus widths
    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int strb_w = data_w / 8;

    // axi response codes
    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    // cpu side request held by the port until its response pulse
    typedef struct packed {
        logic              ce;
        logic              we;
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] wdata;
        logic [strb_w-1:0] wmask;
    } sram_req_t;

    // cpu side response with one cycle pulses
    typedef struct packed {
        logic [data_w-1:0] rdata;
        logic              rdata_valid;
        logic              write_finish;
        logic              err;
    } sram_rsp_t;

    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [2:0]        prot;
    } axi_ar_t;

    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [2:0]        prot;
    } axi_aw_t;

    typedef struct packed {
        logic [data_w-1:0] data;
        logic [strb_w-1:0] strb;
    } axi_w_t;

    typedef struct packed {
        logic [data_w-1:0] data;
        logic [1:0]        resp;
    } axi_r_t;

    typedef struct packed {
        logic [1:0] resp;
    } axi_b_t;

    // request as captured by the controller
    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] wdata;
        logic [strb_w-1:0] wmask;
    } bridge_op_t;

endpackage

// ==== src/axi_read_path.sv ====
`timescale 1ns/1ns

module axi_read_path (
    input  logic                       aclk,
    input  logic                       reset,
    input  logic                       rd_start,
    input  axi_bridge_pkg::bridge_op_t op,
    output axi_bridge_pkg::axi_ar_t    ar,
    output logic                       ar_valid,
    input  logic                       ar_ready,
    input  axi_bridge_pkg::axi_r_t     r,
    input  logic                       r_valid,
    output logic                       r_ready,
    output logic                       rd_done,
    output axi_bridge_pkg::axi_r_t     rd_resp
);

    logic ar_hs;
    logic r_hs;

    assign ar_hs = ar_valid && ar_ready;
    assign r_hs  = r_valid && r_ready;

    always_ff @(posedge aclk) begin
        if (!reset) begin
            ar_valid <= 1'b0;
            r_ready  <= 1'b0;
        end else begin
            // ar_valid stays up through slave stalls
            if (rd_start) begin
                ar_valid <= 1'b1;
            end else if (ar_hs) begin
                ar_valid <= 1'b0;
            end

            // accept the beat only once the address is gone
            if (ar_hs) begin
                r_ready <= 1'b1;
            end else if (r_hs) begin
                r_ready <= 1'b0;
            end
        end
    end

    // address register with prot fixed at zero
    always_ff @(posedge aclk) begin
        if (rd_start) begin
            ar.addr <= op.addr;
            ar.prot <= 3'b000;
        end
    end

    assign rd_done = r_hs;
    assign rd_resp = r;

endmodule

// ==== src/axi_sram_slave.sv ====
`timescale 1ns/1ns

module axi_sram_slave #(
    parameter int MEM_WORDS_LOG2 = 10,
    parameter int MEM_WAIT       = 2
) (
    input  logic                    aclk,
    input  logic                    reset,
    input  axi_bridge_pkg::axi_ar_t ar,
    input  logic                    ar_valid,
    output logic                    ar_ready,
    output axi_bridge_pkg::axi_r_t  r,
    output logic                    r_valid,
    input  logic                    r_ready,
    input  axi_bridge_pkg::axi_aw_t aw,
    input  logic                    aw_valid,
    output logic                    aw_ready,
    input  axi_bridge_pkg::axi_w_t  w,
    input  logic                    w_valid,
    output logic                    w_ready,
    output axi_bridge_pkg::axi_b_t  b,
    output logic                    b_valid,
    input  logic                    b_ready
);

    localparam int mem_words = 1 << MEM_WORDS_LOG2;
    localparam int cnt_w     = $clog2(MEM_WAIT + 1);

    logic [axi_bridge_pkg::data_w-1:0] mem [0:mem_words-1];

    logic                              r_busy;
    logic [cnt_w-1:0]                  r_cnt;
    logic                              b_busy;
    logic [cnt_w-1:0]                  b_cnt;
    logic                              aw_got;
    logic                              w_got;
    axi_bridge_pkg::axi_aw_t           aw_q;
    axi_bridge_pkg::axi_w_t            w_q;
    logic                              ar_hs;
    logic                              aw_hs;
    logic                              w_hs;
    logic                              wr_fire;
    logic [axi_bridge_pkg::addr_w-1:0] wr_addr;
    axi_bridge_pkg::axi_w_t            wr_beat;

    // word index must fit in the memory
    function automatic logic in_range(input logic [axi_bridge_pkg::addr_w-1:0] addr);
        return (addr >> (MEM_WORDS_LOG2 + 2)) == '0;
    endfunction

    assign ar_ready = !r_busy;
    assign r_valid  = r_busy && (r_cnt == '0);
    assign aw_ready = !aw_got && !b_busy;
    assign w_ready  = !w_got && !b_busy;
    assign b_valid  = b_busy && (b_cnt == '0);

    assign ar_hs = ar_valid && ar_ready;
    assign aw_hs = aw_valid && aw_ready;
    assign w_hs  = w_valid && w_ready;

    // write fires on the later of the two transfers
    assign wr_fire = (aw_got || aw_hs) && (w_got || w_hs);
    assign wr_addr = aw_got ? aw_q.addr : aw.addr;
    assign wr_beat = w_got ? w_q : w;

    always_ff @(posedge aclk) begin
        if (!reset) begin
            r_busy <= 1'b0;
            r_cnt  <= '0;
            b_busy <= 1'b0;
            b_cnt  <= '0;
            aw_got <= 1'b0;
            w_got  <= 1'b0;
        end else begin
            if (ar_hs) begin
                r_busy <= 1'b1;
                r_cnt  <= cnt_w'(MEM_WAIT - 1);
            end else if (r_valid && r_ready) begin
                r_busy <= 1'b0;
            end else if (r_cnt != '0) begin
                r_cnt <= r_cnt - 1'b1;
            end

            if (wr_fire) begin
                aw_got <= 1'b0;
                w_got  <= 1'b0;
                b_busy <= 1'b1;
                b_cnt  <= cnt_w'(MEM_WAIT - 1);
            end else begin
                if (aw_hs) begin
                    aw_got <= 1'b1;
                end
                if (w_hs) begin
                    w_got <= 1'b1;
                end
                // b held until the master takes it
                if (b_valid && b_ready) begin
                    b_busy <= 1'b0;
                end else if (b_cnt != '0) begin
                    b_cnt <= b_cnt - 1'b1;
                end
            end
        end
    end

    // memory and response payloads
    always_ff @(posedge aclk) begin
        if (aw_hs) begin
            aw_q <= aw;
        end
        if (w_hs) begin
            w_q <= w;
        end
        if (ar_hs) begin
            r.data <= in_range(ar.addr) ? mem[ar.addr[MEM_WORDS_LOG2+1:2]] : '0;
            r.resp <= in_range(ar.addr) ? axi_bridge_pkg::resp_okay
                                        : axi_bridge_pkg::resp_slverr;
        end
        if (wr_fire) begin
            b.resp <= in_range(wr_addr) ? axi_bridge_pkg::resp_okay
                                        : axi_bridge_pkg::resp_slverr;
            if (in_range(wr_addr)) begin
                for (int i = 0; i < axi_bridge_pkg::strb_w; i++) begin
                    if (wr_beat.strb[i]) begin
                        mem[wr_addr[MEM_WORDS_LOG2+1:2]][8*i +: 8] <= wr_beat.data[8*i +: 8];
                    end
                end
            end
        end
    end

endmodule

// ==== src/axi_write_path.sv ====
`timescale 1ns/1ns

module axi_write_path (
    input  logic                       aclk,
    input  logic                       reset,
    input  logic                       wr_start,
    input  axi_bridge_pkg::bridge_op_t op,
    output axi_bridge_pkg::axi_aw_t    aw,
    output logic                       aw_valid,
    input  logic                       aw_ready,
    output axi_bridge_pkg::axi_w_t     w,
    output logic                       w_valid,
    input  logic                       w_ready,
    input  axi_bridge_pkg::axi_b_t     b,
    input  logic                       b_valid,
    output logic                       b_ready,
    output logic                       wr_done,
    output axi_bridge_pkg::axi_b_t     wr_resp
);

    logic active;
    logic aw_sent;
    logic w_sent;
    logic aw_hs;
    logic w_hs;
    logic b_hs;

    // valids depend on registers and never on ready
    assign aw_valid = active && !aw_sent;
    assign w_valid  = active && !w_sent;
    assign b_ready  = active && aw_sent && w_sent;

    assign aw_hs = aw_valid && aw_ready;
    assign w_hs  = w_valid && w_ready;
    assign b_hs  = b_valid && b_ready;

    always_ff @(posedge aclk) begin
        if (!reset) begin
            active  <= 1'b0;
            aw_sent <= 1'b0;
            w_sent  <= 1'b0;
        end else begin
            if (wr_start) begin
                active  <= 1'b1;
                aw_sent <= 1'b0;
                w_sent  <= 1'b0;
            end else if (b_hs) begin
                active  <= 1'b0;
                aw_sent <= 1'b0;
                w_sent  <= 1'b0;
            end else begin
                // address and data may go in either order
                if (aw_hs) begin
                    aw_sent <= 1'b1;
                end
                if (w_hs) begin
                    w_sent <= 1'b1;
                end
            end
        end
    end

    // channel payloads
    always_ff @(posedge aclk) begin
        if (wr_start) begin
            aw.addr <= op.addr;
            aw.prot <= 3'b000;
            w.data  <= op.wdata;
            w.strb  <= op.wmask;
        end
    end

    assign wr_done = b_hs;
    assign wr_resp = b;

endmodule

// ==== src/bridge_ctrl.sv ====
`timescale 1ns/1ns

module bridge_ctrl (
    input  logic                       aclk,
    input  logic                       reset,
    input  axi_bridge_pkg::sram_req_t  inst_req,
    input  axi_bridge_pkg::sram_req_t  data_req,
    input  logic                       flush,
    output axi_bridge_pkg::sram_rsp_t  inst_rsp,
    output axi_bridge_pkg::sram_rsp_t  data_rsp,
    output logic                       rd_start,
    output logic                       wr_start,
    output axi_bridge_pkg::bridge_op_t op,
    input  logic                       rd_done,
    input  axi_bridge_pkg::axi_r_t     rd_resp,
    input  logic                       wr_done,
    input  axi_bridge_pkg::axi_b_t     wr_resp
);

    typedef enum logic [1:0] {
        st_idle,
        st_read,
        st_write,
        st_release
    } state_t;

    state_t                    state;
    // 0 = data port, 1 = instruction port
    logic                      owner;
    logic                      flushed;
    logic                      grant;
    axi_bridge_pkg::sram_req_t sel;
    logic                      rd_beat;
    logic                      wr_beat;
    logic                      rd_err;
    logic                      wr_err;
    axi_bridge_pkg::sram_rsp_t rsp;

    // data port has priority
    assign grant = data_req.ce || inst_req.ce;
    assign sel   = data_req.ce ? data_req : inst_req;

    always_ff @(posedge aclk) begin
        if (!reset) begin
            state    <= st_idle;
            owner    <= 1'b0;
            flushed  <= 1'b0;
            rd_start <= 1'b0;
            wr_start <= 1'b0;
        end else begin
            rd_start <= 1'b0;
            wr_start <= 1'b0;
            case (state)
                st_idle: begin
                    if (grant) begin
                        owner    <= !data_req.ce;
                        rd_start <= !sel.we;
                        wr_start <= sel.we;
                        state    <= sel.we ? st_write : st_read;
                    end
                end
                st_read: begin
                    // the axi read still runs to completion after a flush
                    if (flush) begin
                        flushed <= 1'b1;
                    end
                    if (rd_done) begin
                        state <= st_release;
                    end
                end
                st_write: begin
                    if (wr_done) begin
                        state <= st_release;
                    end
                end
                default: begin
                    // one dead cycle so a late ce drop is not taken again
                    flushed <= 1'b0;
                    state   <= st_idle;
                end
            endcase
        end
    end

    // captured request payload
    always_ff @(posedge aclk) begin
        if (state == st_idle && grant) begin
            op.addr  <= sel.addr;
            op.wdata <= sel.wdata;
            op.wmask <= sel.wmask;
        end
    end

    always_comb begin
        rd_beat = (state == st_read) && rd_done && !flushed && !flush;
        wr_beat = (state == st_write) && wr_done;
        rd_err  = rd_resp.resp == axi_bridge_pkg::resp_slverr;
        wr_err  = wr_resp.resp == axi_bridge_pkg::resp_slverr;

        rsp.rdata        = rd_resp.data;
        rsp.rdata_valid  = rd_beat;
        rsp.write_finish = wr_beat;
        rsp.err          = (rd_beat && rd_err) || (wr_beat && wr_err);
    end

    // only the owner sees the response
    assign data_rsp = owner ? '0 : rsp;
    assign inst_rsp = owner ? rsp : '0;

endmodule

// ==== src/cpu_axi_subsys.sv ====
`timescale 1ns/1ns

module cpu_axi_subsys #(
    parameter int MEM_WORDS_LOG2 = 10,
    parameter int MEM_WAIT       = 2
) (
    input  logic                      aclk,
    input  logic                      reset,
    input  axi_bridge_pkg::sram_req_t inst_req,
    input  axi_bridge_pkg::sram_req_t data_req,
    input  logic                      flush,
    output axi_bridge_pkg::sram_rsp_t inst_rsp,
    output axi_bridge_pkg::sram_rsp_t data_rsp
);

    // controller to paths
    logic                       rd_start;
    logic                       wr_start;
    axi_bridge_pkg::bridge_op_t op;
    logic                       rd_done;
    axi_bridge_pkg::axi_r_t     rd_resp;
    logic                       wr_done;
    axi_bridge_pkg::axi_b_t     wr_resp;

    // axi channels
    axi_bridge_pkg::axi_ar_t    ar;
    logic                       ar_valid;
    logic                       ar_ready;
    axi_bridge_pkg::axi_r_t     r;
    logic                       r_valid;
    logic                       r_ready;
    axi_bridge_pkg::axi_aw_t    aw;
    logic                       aw_valid;
    logic                       aw_ready;
    axi_bridge_pkg::axi_w_t     w;
    logic                       w_valid;
    logic                       w_ready;
    axi_bridge_pkg::axi_b_t     b;
    logic                       b_valid;
    logic                       b_ready;

    bridge_ctrl bridge_ctrl_inst (
        .aclk     (aclk),
        .reset    (reset),
        .inst_req (inst_req),
        .data_req (data_req),
        .flush    (flush),
        .inst_rsp (inst_rsp),
        .data_rsp (data_rsp),
        .rd_start (rd_start),
        .wr_start (wr_start),
        .op       (op),
        .rd_done  (rd_done),
        .rd_resp  (rd_resp),
        .wr_done  (wr_done),
        .wr_resp  (wr_resp)
    );

    axi_read_path axi_read_path_inst (
        .aclk     (aclk),
        .reset    (reset),
        .rd_start (rd_start),
        .op       (op),
        .ar       (ar),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .r        (r),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .rd_done  (rd_done),
        .rd_resp  (rd_resp)
    );

    axi_write_path axi_write_path_inst (
        .aclk     (aclk),
        .reset    (reset),
        .wr_start (wr_start),
        .op       (op),
        .aw       (aw),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .w        (w),
        .w_valid  (w_valid),
        .w_ready  (w_ready),
        .b        (b),
        .b_valid  (b_valid),
        .b_ready  (b_ready),
        .wr_done  (wr_done),
        .wr_resp  (wr_resp)
    );

    axi_sram_slave #(
        .MEM_WORDS_LOG2 (MEM_WORDS_LOG2),
        .MEM_WAIT       (MEM_WAIT)
    ) axi_sram_slave_inst (
        .aclk     (aclk),
        .reset    (reset),
        .ar       (ar),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .r        (r),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .aw       (aw),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .w        (w),
        .w_valid  (w_valid),
        .w_ready  (w_ready),
        .b        (b),
        .b_valid  (b_valid),
        .b_ready  (b_ready)
    );

endmodule

// ==== test/cpu_axi_subsys_tb.sv ====
`timescale 1ns/1ns

module cpu_axi_subsys_tb;

    localparam int mem_words_log2 = 10;
    localparam int mem_wait       = 2;
    localparam int num_ops        = 400;
    localparam int timeout_cycles = num_ops * (mem_wait + 12);
    // traffic stays in a small window so every word is known to the model
    localparam int win_words      = 16;
    localparam logic port_data    = 1'b0;
    localparam logic port_inst    = 1'b1;

    logic                      aclk;
    logic                      reset;
    axi_bridge_pkg::sram_req_t inst_req;
    axi_bridge_pkg::sram_req_t data_req;
    logic                      flush;
    axi_bridge_pkg::sram_rsp_t inst_rsp;
    axi_bridge_pkg::sram_rsp_t data_rsp;

    // outputs sampled at the falling edge before new inputs go out
    axi_bridge_pkg::sram_rsp_t inst_s;
    axi_bridge_pkg::sram_rsp_t data_s;

    logic [7:0]  model_mem [0:win_words*4-1];
    logic [31:0] lfsr        = 32'h61a6_0400;
    int          cycle_count = 0;

    cpu_axi_subsys #(
        .MEM_WORDS_LOG2 (mem_words_log2),
        .MEM_WAIT       (mem_wait)
    ) cpu_axi_subsys_inst (
        .aclk     (aclk),
        .reset    (reset),
        .inst_req (inst_req),
        .data_req (data_req),
        .flush    (flush),
        .inst_rsp (inst_rsp),
        .data_rsp (data_rsp)
    );

    initial begin
        aclk = 1'b0;
        forever begin
            #20 aclk = ~aclk;
        end
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "stopped at the first error");
    endtask

    always @(posedge aclk) begin
        cycle_count++;
        if (cycle_count > timeout_cycles) begin
            stop_with_failure($sformatf("timeout, no end of test after %0d cycles", cycle_count));
        end
    end

    // galois form with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return v;
    endfunction

    function automatic logic addr_err(input logic [axi_bridge_pkg::addr_w-1:0] addr);
        return (addr >> 2) >= (32'd1 << mem_words_log2);
    endfunction

    function automatic logic [axi_bridge_pkg::data_w-1:0] model_read(
        input logic [axi_bridge_pkg::addr_w-1:0] addr
    );
        int base;
        base = 4 * int'(addr[5:2]);
        if (addr_err(addr)) begin
            return '0;
        end
        return {model_mem[base+3], model_mem[base+2], model_mem[base+1], model_mem[base]};
    endfunction

    task automatic model_write(input axi_bridge_pkg::sram_req_t req);
        int base;
        base = 4 * int'(req.addr[5:2]);
        if (!addr_err(req.addr)) begin
            for (int i = 0; i < axi_bridge_pkg::strb_w; i++) begin
                if (req.wmask[i]) begin
                    model_mem[base+i] = req.wdata[8*i +: 8];
                end
            end
        end
    endtask

    // mostly in range and about one in eight above the memory
    function automatic logic [axi_bridge_pkg::addr_w-1:0] pick_addr();
        logic       oor;
        logic [3:0] word;
        logic [4:0] hi;
        oor  = rand_bits(3) == 0;
        word = rand_bits(4);
        hi   = rand_bits(5);
        if (oor) begin
            return (32'd1 << (mem_words_log2 + 2 + hi % (30 - mem_words_log2))) | {word, 2'b00};
        end
        return {26'd0, word, 2'b00};
    endfunction

    function automatic axi_bridge_pkg::sram_req_t make_req(
        input logic                              we,
        input logic [axi_bridge_pkg::addr_w-1:0] addr,
        input logic [axi_bridge_pkg::data_w-1:0] wdata,
        input logic [axi_bridge_pkg::strb_w-1:0] wmask
    );
        axi_bridge_pkg::sram_req_t req;
        req.ce    = 1'b1;
        req.we    = we;
        req.addr  = addr;
        req.wdata = wdata;
        req.wmask = wmask;
        return req;
    endfunction

    function automatic axi_bridge_pkg::sram_req_t random_req();
        logic                              we;
        logic [axi_bridge_pkg::addr_w-1:0] addr;
        logic [axi_bridge_pkg::data_w-1:0] wdata;
        logic [axi_bridge_pkg::strb_w-1:0] wmask;
        we    = rand_bits(1);
        addr  = pick_addr();
        wdata = rand_bits(32);
        wmask = rand_bits(4);
        return make_req(we, addr, wdata, wmask);
    endfunction

    function automatic string rsp_name(input logic port);
        return port ? "inst_rsp" : "data_rsp";
    endfunction

    function automatic logic is_pulse(input axi_bridge_pkg::sram_rsp_t rsp);
        return (rsp.rdata_valid === 1'b1) || (rsp.write_finish === 1'b1);
    endfunction

    task automatic step();
        @(negedge aclk);
        inst_s = inst_rsp;
        data_s = data_rsp;
    endtask

    task automatic drive_port(input logic port, input axi_bridge_pkg::sram_req_t req);
        if (port == port_inst) begin
            inst_req = req;
        end else begin
            data_req = req;
        end
    endtask

    task automatic expect_quiet(input string why);
        if (inst_s.rdata_valid !== 1'b0 || inst_s.write_finish !== 1'b0 || inst_s.err !== 1'b0 ||
            data_s.rdata_valid !== 1'b0 || data_s.write_finish !== 1'b0 || data_s.err !== 1'b0) begin
            stop_with_failure(why);
        end
    endtask

    task automatic check_finish_port(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("FAIL %0t ns: %s got %0d expected %0d",
                                        $time, name, got, exp));
        end
    endtask

    task automatic check_rsp_data(
        input string                             name,
        input axi_bridge_pkg::sram_rsp_t         got,
        input logic                              exp_write,
        input logic [axi_bridge_pkg::data_w-1:0] exp_data,
        input logic                              exp_err
    );
        if (got.write_finish !== exp_write) begin
            stop_with_failure($sformatf("FAIL %0t ns: %s.write_finish got %0d expected %0d",
                                        $time, name, got.write_finish, exp_write));
        end
        if (got.rdata_valid !== !exp_write) begin
            stop_with_failure($sformatf("FAIL %0t ns: %s.rdata_valid got %0d expected %0d",
                                        $time, name, got.rdata_valid, !exp_write));
        end
        if (got.err !== exp_err) begin
            stop_with_failure($sformatf("FAIL %0t ns: %s.err got %0d expected %0d",
                                        $time, name, got.err, exp_err));
        end
        if (!exp_write && got.rdata !== exp_data) begin
            stop_with_failure($sformatf("FAIL %0t ns: %s.rdata got %h expected %h",
                                        $time, name, got.rdata, exp_data));
        end
    endtask

    // first response pulse on either port
    task automatic wait_pulse(output logic port, output axi_bridge_pkg::sram_rsp_t got);
        logic inst_hit;
        logic data_hit;
        inst_hit = 1'b0;
        data_hit = 1'b0;
        while (!inst_hit && !data_hit) begin
            step();
            inst_hit = is_pulse(inst_s);
            data_hit = is_pulse(data_s);
        end
        if (inst_hit && data_hit) begin
            stop_with_failure("both ports got a response pulse in the same cycle");
        end
        port = inst_hit ? port_inst : port_data;
        got  = inst_hit ? inst_s : data_s;
    endtask

    task automatic finish_request(input logic port, input axi_bridge_pkg::sram_req_t req);
        logic                      got_port;
        axi_bridge_pkg::sram_rsp_t got;
        wait_pulse(got_port, got);
        drive_port(port, '0);
        check_finish_port("response port", got_port, port);
        check_rsp_data(rsp_name(port), got, req.we, model_read(req.addr), addr_err(req.addr));
        if (req.we) begin
            model_write(req);
        end
    endtask

    task automatic run_single(input logic port, input axi_bridge_pkg::sram_req_t req);
        drive_port(port, req);
        finish_request(port, req);
    endtask

    // data port has to answer first
    task automatic run_pair(input axi_bridge_pkg::sram_req_t dreq,
                            input axi_bridge_pkg::sram_req_t ireq);
        data_req = dreq;
        inst_req = ireq;
        finish_request(port_data, dreq);
        finish_request(port_inst, ireq);
    endtask

    task automatic run_flushed_read(input logic port, input logic [31:0] addr, input logic late);
        axi_bridge_pkg::sram_req_t req;
        req = make_req(1'b0, addr, '0, '0);
        // let the controller get back to idle first
        step();
        step();
        drive_port(port, req);
        step();
        expect_quiet("response pulse while a read was still pending");
        if (late) begin
            step();
            expect_quiet("response pulse while a read was still pending");
        end
        flush = 1'b1;
        drive_port(port, '0);
        step();
        flush = 1'b0;
        for (int i = 0; i < mem_wait + 8; i++) begin
            expect_quiet("a response pulse appeared for a flushed read");
            step();
        end
        expect_quiet("a response pulse appeared for a flushed read");
        run_single(!port, req);
    endtask

    initial begin
        logic [2:0]                kind;
        logic                      port;
        logic                      late;
        logic [31:0]               addr;
        axi_bridge_pkg::sram_req_t req_a;
        axi_bridge_pkg::sram_req_t req_b;

        inst_req = '0;
        data_req = '0;
        flush    = 1'b0;
        reset    = 1'b0;
        repeat (10) @(posedge aclk);
        @(negedge aclk);
        reset = 1'b1;

        for (int i = 0; i < 20; i++) begin
            step();
            expect_quiet("response output active after reset with no request");
        end

        // fill the window with known words
        for (int i = 0; i < win_words; i++) begin
            run_single(i[0], make_req(1'b1, i << 2, rand_bits(32), 4'hf));
        end

        for (int n = 0; n < num_ops - win_words; n++) begin
            kind = rand_bits(3);
            if (kind == 0) begin
                req_a = random_req();
                req_b = random_req();
                run_pair(req_a, req_b);
            end else if (kind == 1) begin
                port = rand_bits(1);
                addr = pick_addr();
                late = rand_bits(1);
                run_flushed_read(port, addr, late);
            end else begin
                port  = rand_bits(1);
                req_a = random_req();
                run_single(port, req_a);
            end
        end

        $display("sim passed");
        $finish;
    end

endmodule
